//--- hdl/outlier_settings.svh
`ifndef OUTLIER_SETTINGS_SVH
`define OUTLIER_SETTINGS_SVH

// build-time sizing for the outlier splitter

// channels carried by one beat
`define NUM_CH 8

// signed sample width in bits
`define SAMPLE_W 16

// most outliers routed to the high side per beat
`define NUM_SEL 2

// width of a kept-channel count
// must hold NUM_CH itself, hence the +1
`define SEL_CNT_W $clog2(`NUM_CH + 1)

// vector layout
// channel 0 sits in the low bits of a packed vector
// magnitude keeps the full sample width so that the
// most negative sample has an exact magnitude
// threshold compare is strict, equal is not an outlier

`endif

//--- hdl/sample_pkg.sv
`default_nettype none

`include "outlier_settings.svh"

// sample data types for the splitter datapath
package sample_pkg;

    // one signed channel sample
    typedef logic signed [`SAMPLE_W-1:0] sample_t;

    // unsigned magnitude, same width as a sample
    // 0x8000 is the magnitude of the most negative sample
    typedef logic [`SAMPLE_W-1:0] mag_t;

    // full beat, channel 0 in the low bits
    typedef sample_t [`NUM_CH-1:0] sample_vec_t;

    // magnitude of a signed sample
    // unsigned subtract keeps -32768 exact at 0x8000
    function automatic mag_t mag_of(input sample_t s);
        mag_t m;
        if (s[`SAMPLE_W-1]) begin
            m = mag_t'(0) - mag_t'(s);
        end else begin
            m = mag_t'(s);
        end
        return m;
    endfunction

endpackage

`default_nettype wire

//--- hdl/select_pkg.sv
`default_nettype none

`include "outlier_settings.svh"

// channel selection types
package select_pkg;

    // one bit per channel, bit 0 is channel 0
    typedef logic [`NUM_CH-1:0] chan_mask_t;

    // number of kept or flagged channels
    typedef logic [`SEL_CNT_W-1:0] sel_count_t;

    // population count of a channel mask
    function automatic sel_count_t count_ones(input chan_mask_t m);
        sel_count_t n;
        n = '0;
        // add one per set bit
        for (int i = 0; i < `NUM_CH; i++) begin
            n = n + sel_count_t'(m[i]);
        end
        return n;
    endfunction

    // true if more channels are flagged than can be kept
    function automatic logic over_limit(input sel_count_t n);
        logic ovf;
        ovf = (n > sel_count_t'(`NUM_SEL));
        return ovf;
    endfunction

endpackage

`default_nettype wire

//--- hdl/priority_encoder.sv
`default_nettype none

// picks the lowest-indexed set bits of a flag vector
// at most COUNT bits survive into the mask
// purely combinational
module priority_encoder #(
    parameter int WIDTH = 8,
    parameter int COUNT = 2
) (
    input  logic [WIDTH-1:0] flags,
    output logic [WIDTH-1:0] mask
);

    // flags not yet taken
    logic [WIDTH-1:0] remaining;
    // lowest set bit of remaining on each pass
    logic [WIDTH-1:0] lowest;

    always_comb begin
        remaining = flags;
        mask      = '0;
        lowest    = '0;
        // one pass per kept bit
        for (int k = 0; k < COUNT; k++) begin
            // isolate lowest set bit
            // zero when nothing is left
            lowest    = remaining & ~(remaining - WIDTH'(1));
            // drop it from the working copy
            remaining = remaining & ~lowest;
            // and add it to the result
            mask      = mask | lowest;
        end
    end

    // COUNT >= WIDTH simply passes all flags through
    // COUNT of zero gives an empty mask
    // chain depth grows with COUNT, each pass is a subtract and two ANDs
    // fine for small COUNT
    // a wider search would want a different structure
    // ripple through passes, no registers here
    // caller registers the mask

endmodule

`default_nettype wire

//--- hdl/sample_capture.sv
`default_nettype none

// input stage of the splitter
// registers one beat together with its threshold
module sample_capture
    import sample_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // incoming beat
    input  logic        in_valid,
    input  sample_vec_t in_samples,
    input  mag_t        in_threshold,

    // registered beat toward detect stage
    output logic        cap_valid,
    output sample_vec_t cap_samples,
    output mag_t        cap_threshold
);

    // valid strobe
    // one cycle delay, cleared by reset
    always_ff @(posedge clk) begin
        if (rst) begin
            cap_valid <= 1'b0;
        end else begin
            cap_valid <= in_valid;
        end
    end

    // payload
    // threshold travels with its own beat so it may change every beat
    // held while idle
    always_ff @(posedge clk) begin
        if (in_valid) begin
            cap_samples   <= in_samples;
            cap_threshold <= in_threshold;
        end
    end

    // beats may arrive back to back
    // gaps of any length are allowed
    // there is no back-pressure, so nothing holds off a new beat
    // no stall path, stage always advances

endmodule

`default_nettype wire

//--- hdl/outlier_detect.sv
`default_nettype none

`include "outlier_settings.svh"

// detect stage
// magnitude, threshold compare and priority pick are combinational,
// then registered at the stage boundary
module outlier_detect
    import sample_pkg::*;
    import select_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // from capture stage
    input  logic        cap_valid,
    input  sample_vec_t cap_samples,
    input  mag_t        cap_threshold,

    // toward split stage
    output logic        det_valid,
    output sample_vec_t det_samples,
    output chan_mask_t  det_mask,
    output sel_count_t  det_count,
    output logic        det_overflow
);

    // raw outlier flags, one per channel
    chan_mask_t flags;
    // lowest-indexed flags that survive the limit
    chan_mask_t keep_mask;
    // all flagged channels, before the limit
    sel_count_t flag_count;

    // strict compare against threshold
    // equal magnitude is not an outlier
    always_comb begin
        for (int ch = 0; ch < `NUM_CH; ch++) begin
            flags[ch] = (mag_of(cap_samples[ch]) > cap_threshold);
        end
    end

    // keep the first NUM_SEL flags
    priority_encoder #(
        .WIDTH (`NUM_CH),
        .COUNT (`NUM_SEL)
    ) u_priority_encoder (
        .flags (flags),
        .mask  (keep_mask)
    );

    assign flag_count = count_ones(flags);

    // valid pipe
    always_ff @(posedge clk) begin
        if (rst) begin
            det_valid <= 1'b0;
        end else begin
            det_valid <= cap_valid;
        end
    end

    // results registered alongside their samples
    always_ff @(posedge clk) begin
        if (cap_valid) begin
            det_samples  <= cap_samples;
            det_mask     <= keep_mask;
            det_count    <= count_ones(keep_mask);
            det_overflow <= over_limit(flag_count);
        end
    end

endmodule

`default_nettype wire

//--- hdl/precision_split.sv
`default_nettype none

`include "outlier_settings.svh"

// output stage
// kept channels go to the high side, all others to the low side
module precision_split
    import sample_pkg::*;
    import select_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // from detect stage
    input  logic        det_valid,
    input  sample_vec_t det_samples,
    input  chan_mask_t  det_mask,
    input  sel_count_t  det_count,
    input  logic        det_overflow,

    // top-level results
    output logic        out_valid,
    output sample_vec_t hi_samples,
    output sample_vec_t lo_samples,
    output chan_mask_t  out_mask,
    output sel_count_t  out_count,
    output logic        out_overflow
);

    // split before the register
    sample_vec_t hi_next;
    sample_vec_t lo_next;

    // each channel lands on exactly one side
    // the other side sees zero
    always_comb begin
        for (int ch = 0; ch < `NUM_CH; ch++) begin
            if (det_mask[ch]) begin
                hi_next[ch] = det_samples[ch];
                lo_next[ch] = '0;
            end else begin
                hi_next[ch] = '0;
                lo_next[ch] = det_samples[ch];
            end
        end
    end

    // outputs are zero whenever no beat is valid
    // so a consumer never sees stale data between beats
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid    <= 1'b0;
            hi_samples   <= '0;
            lo_samples   <= '0;
            out_mask     <= '0;
            out_count    <= '0;
            out_overflow <= 1'b0;
        end else if (det_valid) begin
            out_valid    <= 1'b1;
            hi_samples   <= hi_next;
            lo_samples   <= lo_next;
            out_mask     <= det_mask;
            out_count    <= det_count;
            out_overflow <= det_overflow;
        end else begin
            // idle cycle
            out_valid    <= 1'b0;
            hi_samples   <= '0;
            lo_samples   <= '0;
            out_mask     <= '0;
            out_count    <= '0;
            out_overflow <= 1'b0;
        end
    end

    // hi | lo rebuilds the input beat, hi & lo is always zero
    // per channel that holds bitwise since one side is zeroed
    // overflow only reports, it does not change the split
    // count matches popcount of out_mask

endmodule

`default_nettype wire

//--- hdl/outlier_splitter_top.sv
`default_nettype none

// outlier channel splitter
// three registered stages, fixed latency of three cycles
module outlier_splitter_top
    import sample_pkg::*;
    import select_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // input beat
    input  logic        in_valid,
    input  sample_vec_t in_samples,
    input  mag_t        in_threshold,

    // split results
    output logic        out_valid,
    output sample_vec_t hi_samples,
    output sample_vec_t lo_samples,
    output chan_mask_t  out_mask,
    output sel_count_t  out_count,
    output logic        out_overflow
);

    // capture to detect
    logic        cap_valid;
    sample_vec_t cap_samples;
    mag_t        cap_threshold;

    // detect to split
    logic        det_valid;
    sample_vec_t det_samples;
    chan_mask_t  det_mask;
    sel_count_t  det_count;
    logic        det_overflow;

    // stage 1, input register
    sample_capture u_sample_capture (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_samples    (in_samples),
        .in_threshold  (in_threshold),
        .cap_valid     (cap_valid),
        .cap_samples   (cap_samples),
        .cap_threshold (cap_threshold)
    );

    // stage 2, flag and select
    outlier_detect u_outlier_detect (
        .clk           (clk),
        .rst           (rst),
        .cap_valid     (cap_valid),
        .cap_samples   (cap_samples),
        .cap_threshold (cap_threshold),
        .det_valid     (det_valid),
        .det_samples   (det_samples),
        .det_mask      (det_mask),
        .det_count     (det_count),
        .det_overflow  (det_overflow)
    );

    // stage 3, split into high and low precision sides
    precision_split u_precision_split (
        .clk          (clk),
        .rst          (rst),
        .det_valid    (det_valid),
        .det_samples  (det_samples),
        .det_mask     (det_mask),
        .det_count    (det_count),
        .det_overflow (det_overflow),
        .out_valid    (out_valid),
        .hi_samples   (hi_samples),
        .lo_samples   (lo_samples),
        .out_mask     (out_mask),
        .out_count    (out_count),
        .out_overflow (out_overflow)
    );

endmodule

`default_nettype wire

//--- dv/outlier_splitter_tb.sv
`default_nettype none

`include "outlier_settings.svh"

module outlier_splitter_tb
    import sample_pkg::*;
    import select_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_HALF   = 2;
    localparam int RST_CYCLES = 3;
    localparam int LATENCY    = 3;
    localparam int MAX_VEC    = 64;
    localparam int MAX_TEST   = 16;
    localparam int LFSR_SEED  = 79599;
    localparam int VEC_W      = `NUM_CH * `SAMPLE_W;

    // widest compared value is a full sample vector
    typedef logic [VEC_W-1:0] chk_t;

    logic        clk;
    logic        rst;
    logic        in_valid;
    sample_vec_t in_samples;
    mag_t        in_threshold;
    logic        out_valid;
    sample_vec_t hi_samples;
    sample_vec_t lo_samples;
    chan_mask_t  out_mask;
    sel_count_t  out_count;
    logic        out_overflow;

    // vectors from the data file
    int          vec_test [MAX_VEC];
    mag_t        vec_thr [MAX_VEC];
    sample_vec_t vec_smp [MAX_VEC];
    chan_mask_t  vec_mask [MAX_VEC];
    int          num_vec = 0;

    // beats in flight with index and drive cycle
    int pend_idx[$];
    int pend_cycle[$];

    int test_total [MAX_TEST];
    int test_done [MAX_TEST];
    int test_errs [MAX_TEST];
    int cur_test = 0;
    int errors = 0;
    int checks = 0;
    int checked_vecs = 0;
    int cycle_count = 0;
    int cycle_limit = 0;
    logic [15:0] lfsr;

    outlier_splitter_top dut (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_samples   (in_samples),
        .in_threshold (in_threshold),
        .out_valid    (out_valid),
        .hi_samples   (hi_samples),
        .lo_samples   (lo_samples),
        .out_mask     (out_mask),
        .out_count    (out_count),
        .out_overflow (out_overflow)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // 16-bit fibonacci lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // one random bit per lfsr step
    task automatic take_bit(output logic b);
        b    = lfsr[15];
        lfsr = lfsr_next(lfsr);
    endtask

    // absolute value in plain integer arithmetic
    function automatic int magnitude(input sample_t s);
        int v;
        v = int'(s);
        if (v < 0) begin
            v = -v;
        end
        return v;
    endfunction

    // strict threshold rule per channel
    function automatic chan_mask_t flags_of(input sample_vec_t v, input mag_t thr);
        chan_mask_t f;
        for (int ch = 0; ch < `NUM_CH; ch++) begin
            f[ch] = (magnitude(v[ch]) > int'(thr));
        end
        return f;
    endfunction

    // scan upward keeping the first NUM_SEL flags
    function automatic chan_mask_t pick_lowest(input chan_mask_t f);
        chan_mask_t m;
        int kept;
        m    = '0;
        kept = 0;
        for (int ch = 0; ch < `NUM_CH; ch++) begin
            if (f[ch] && kept < `NUM_SEL) begin
                m[ch] = 1'b1;
                kept++;
            end
        end
        return m;
    endfunction

    function automatic int bit_count(input chan_mask_t m);
        int n;
        n = 0;
        for (int ch = 0; ch < `NUM_CH; ch++) begin
            if (m[ch]) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic check_value(input string name, input chk_t exp, input chk_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            test_errs[cur_test]++;
            $display("ERR t=%0t %s expected %0h got %0h", $time, name, exp, act);
        end
    endtask

    // one line per vector holds test thr s0..s7 mask
    task automatic load_vectors();
        int fd;
        int rc;
        int t;
        string line;
        mag_t thr;
        chan_mask_t msk;
        logic [`SAMPLE_W-1:0] s [`NUM_CH];
        fd = $fopen("dv/outlier_testdata.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the test data file");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            rc = $fgets(line, fd);
            // skip blank and comment lines
            if (rc > 1 && line.getc(0) != "#") begin
                rc = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h", t, thr,
                             s[0], s[1], s[2], s[3], s[4], s[5], s[6], s[7], msk);
                if (rc != 11 || t < 1 || t >= MAX_TEST || num_vec >= MAX_VEC) begin
                    errors++;
                    $display("bad or surplus line in test data: %s", line);
                end else begin
                    vec_test[num_vec] = t;
                    vec_thr[num_vec]  = thr;
                    vec_mask[num_vec] = msk;
                    for (int ch = 0; ch < `NUM_CH; ch++) begin
                        vec_smp[num_vec][ch] = s[ch];
                    end
                    test_total[t]++;
                    // the file's mask must follow the selection rule
                    cur_test = t;
                    check_value("testdata mask",
                                chk_t'(pick_lowest(flags_of(vec_smp[num_vec], thr))),
                                chk_t'(msk));
                    num_vec++;
                end
            end
        end
        $fclose(fd);
        cur_test = 0;
    endtask

    task automatic check_outputs();
        int idx;
        int drove;
        int t;
        chan_mask_t exp_mask;
        sample_vec_t exp_hi;
        sample_vec_t exp_lo;
        int exp_count;
        logic exp_ovf;
        if (!out_valid) begin
            // idle cycles see all outputs cleared
            check_value("hi_samples", '0, chk_t'(hi_samples));
            check_value("lo_samples", '0, chk_t'(lo_samples));
            check_value("out_mask", '0, chk_t'(out_mask));
            check_value("out_count", '0, chk_t'(out_count));
            check_value("out_overflow", '0, chk_t'(out_overflow));
        end else if (pend_idx.size() == 0) begin
            errors++;
            $display("out_valid was high at %0t with no beat in flight", $time);
        end else begin
            idx      = pend_idx.pop_front();
            drove    = pend_cycle.pop_front();
            t        = vec_test[idx];
            cur_test = t;
            exp_mask = vec_mask[idx];
            // kept channels go high and the rest low
            for (int ch = 0; ch < `NUM_CH; ch++) begin
                exp_hi[ch] = exp_mask[ch] ? vec_smp[idx][ch] : '0;
                exp_lo[ch] = exp_mask[ch] ? '0 : vec_smp[idx][ch];
            end
            exp_count = bit_count(exp_mask);
            exp_ovf   = (bit_count(flags_of(vec_smp[idx], vec_thr[idx])) > `NUM_SEL);
            check_value("latency", chk_t'(LATENCY), chk_t'(cycle_count - drove));
            check_value("out_mask", chk_t'(exp_mask), chk_t'(out_mask));
            check_value("out_count", chk_t'(exp_count), chk_t'(out_count));
            check_value("out_overflow", chk_t'(exp_ovf), chk_t'(out_overflow));
            check_value("hi_samples", chk_t'(exp_hi), chk_t'(hi_samples));
            check_value("lo_samples", chk_t'(exp_lo), chk_t'(lo_samples));
            checked_vecs++;
            test_done[t]++;
            if (test_done[t] == test_total[t]) begin
                $display("test %0d: %0d vectors, %0d errors", t, test_total[t], test_errs[t]);
            end
        end
    endtask

    // cycle count and run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("run stopped at cycle %0d, results never arrived", cycle_count);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // outputs are stable mid-cycle
    always @(negedge clk) begin
        if (cycle_count > RST_CYCLES) begin
            check_outputs();
        end
    end

    initial begin
        logic b0;
        logic b1;
        int gap;
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_samples   = '0;
        in_threshold = '0;
        // seed folded to the register width
        lfsr         = LFSR_SEED[15:0];
        load_vectors();
        cycle_limit = num_vec * 8 + 50;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // outputs must stay zero before any beat
        repeat (4) @(negedge clk);
        @(posedge clk);
        $display("test 1: reset and idle outputs, %0d errors", test_errs[0]);
        for (int i = 0; i < num_vec; i++) begin
            @(negedge clk);
            // zero to three idle cycles
            take_bit(b0);
            take_bit(b1);
            gap      = int'({b1, b0});
            in_valid = 1'b0;
            repeat (gap) @(negedge clk);
            in_valid     = 1'b1;
            in_samples   = vec_smp[i];
            in_threshold = vec_thr[i];
            pend_idx.push_back(i);
            pend_cycle.push_back(cycle_count);
        end
        @(negedge clk);
        in_valid = 1'b0;
        // drain the pipe
        for (int w = 0; w < 2 * LATENCY && pend_idx.size() > 0; w++) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        @(posedge clk);
        if (pend_idx.size() > 0) begin
            errors++;
            $display("%0d beats never came out of the pipeline", pend_idx.size());
        end
        if (num_vec == 0) begin
            errors++;
            $display("no vectors were loaded");
        end
        $display("done: %0d vectors, %0d checked, %0d checks, %0d errors",
                 num_vec, checked_vecs, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- outlier_splitter_top.f
+incdir+hdl
hdl/sample_pkg.sv
hdl/select_pkg.sv
hdl/priority_encoder.sv
hdl/sample_capture.sv
hdl/outlier_detect.sv
hdl/precision_split.sv
hdl/outlier_splitter_top.sv
dv/outlier_splitter_tb.sv

//--- Makefile
SIM      = verilator
SIMFLAGS = --binary --timing --timescale 1ns/1ps -j 0
TOP      = outlier_splitter_tb
FLIST    = outlier_splitter_top.f

OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
SOURCES  = $(filter-out +incdir+%,$(shell cat $(FLIST))) hdl/outlier_settings.svh
PASS_MSG = TESTBENCH PASSED

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FLIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FLIST)

# status comes from the search for the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

//--- dv/outlier_testdata.txt
# test threshold s0 s1 s2 s3 s4 s5 s6 s7 mask, all but test in hex
# s0 is channel 0, mask is the expected kept-channel mask
2 7fff 0000 1234 7fff 8001 4000 c000 0001 ffff 00
2 0100 0100 ff00 0000 00ff ff01 0010 fff0 0080 00
2 0000 0000 0000 0000 0000 0000 0000 0000 0000 00
2 1000 0fff f001 0800 f800 0000 1000 f000 0001 00
3 0100 0000 0000 0000 0200 0000 0000 0000 0000 08
3 0100 0000 0000 0000 0000 0000 0000 0000 fe00 80
3 1000 1001 0000 0000 0000 0000 0000 0000 0000 01
3 0050 0010 0020 0030 0040 0050 0060 0050 0040 20
3 7000 0000 0000 0000 0000 8fff 0000 0000 0000 10
4 0100 0200 0200 0200 0200 0200 0200 0200 0200 03
4 0100 0000 0300 0000 fd00 0000 0400 0000 0500 0a
4 0010 0001 0002 0003 0011 0001 ffe0 0100 0000 28
4 4000 0000 0000 0000 0000 0000 8000 7fff bfff 60
4 0000 0001 0000 0000 0000 0000 0000 ffff 0001 41
5 0200 0200 fe00 0201 0000 0000 0000 0000 0000 04
5 7fff 8000 0000 0000 0000 0000 0000 0000 0000 01
5 7fff 0000 0000 0000 0000 0000 0000 7fff 8000 80
5 0005 fffb fffa 0005 0006 0000 0000 0000 0000 0a
5 8000 8000 8000 7fff 8001 0000 0000 0000 0000 00
5 ffff 8000 7fff 0000 0000 0000 0000 0000 0000 00
5 0000 0000 0000 0000 ffff 0000 0000 0000 0000 08
6 0100 0101 0000 0000 0000 0000 0000 0000 0101 81
6 0020 0021 ffdf 0021 0000 0000 0000 0000 0000 03
6 1234 1235 0000 0000 edcb 0000 0000 0000 0000 09
6 0000 0000 0000 0000 0000 0000 0000 0000 0000 00
6 0800 0000 0000 0000 0000 0000 0900 f600 0000 60
6 3fff 4000 4000 4000 4000 4000 4000 4000 4000 03
6 0400 0000 0000 0000 0000 0000 0000 0000 0000 00
6 0001 0000 0000 0002 0000 0000 0000 0000 0000 04
6 00ff ff00 0000 0000 0000 0000 0000 0000 0000 01
6 5555 aaaa 5556 5555 0000 0000 0000 0000 0000 03
